//--- hw/dbg_pkg.sv
package dbg_pkg;

    localparam int NB_BYTE = 8;
    localparam int NB_WORD = 32;

    // Opcodes of the supported MIPS subset
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] OP_HALT  = 6'h3F;

    // R-type function field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;

    // Debug command bytes, ASCII
    localparam logic [7:0] CMD_LOAD = 8'h4C;
    localparam logic [7:0] CMD_CONT = 8'h43;
    localparam logic [7:0] CMD_STEP = 8'h53;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COUNT,
        ST_LOAD,
        ST_WAIT_CMD,
        ST_RUN,
        ST_STEP,
        ST_DUMP
    } debug_state_t;

endpackage

//--- hw/debug_loader.sv
`timescale 1ns/100ps

module debug_loader #(
    parameter int NB_IM_ADDR = 4
) (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_rx_done,
    input  logic [dbg_pkg::NB_BYTE-1:0] i_rx_data,
    input  logic                        i_hlt,
    input  logic                        i_dump_done,
    output logic                        o_im_we,
    output logic [NB_IM_ADDR-1:0]       o_im_addr,
    output logic [dbg_pkg::NB_WORD-1:0] o_im_data,
    output logic                        o_core_enable,
    output logic                        o_core_clear,
    output logic                        o_dump_start,
    output dbg_pkg::debug_state_t       o_state
);
    import dbg_pkg::*;

    debug_state_t                 state;
    logic [NB_BYTE-1:0]           num_words;
    logic [NB_BYTE-1:0]           word_cnt;
    logic [1:0]                   byte_cnt;
    logic [NB_WORD-NB_BYTE-1:0]   word_sr;
    logic                         load_byte;

    assign load_byte = i_rx_done && (state == ST_LOAD);

    // A load command restarts the core from a clean state
    assign o_core_clear = i_rx_done && (i_rx_data == CMD_LOAD)
                          && (state == ST_IDLE || state == ST_WAIT_CMD);

    // Fourth byte goes straight into memory along with the three before it
    assign o_im_we   = load_byte && (byte_cnt == 2'd3);
    assign o_im_addr = NB_IM_ADDR'(word_cnt);
    assign o_im_data = {word_sr, i_rx_data};

    assign o_core_enable = (state == ST_RUN) || (state == ST_STEP);
    assign o_state       = state;

    always_ff @(posedge i_clock) begin
        if (load_byte) begin
            word_sr <= {word_sr[NB_WORD-2*NB_BYTE-1:0], i_rx_data};
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state        <= ST_IDLE;
            num_words    <= '0;
            word_cnt     <= '0;
            byte_cnt     <= '0;
            o_dump_start <= 1'b0;
        end else begin
            o_dump_start <= 1'b0;
            case (state)
                ST_IDLE, ST_WAIT_CMD: begin
                    if (o_core_clear) begin
                        state <= ST_COUNT;
                    end else if (i_rx_done && state == ST_WAIT_CMD) begin
                        if (i_rx_data == CMD_CONT) begin
                            state <= ST_RUN;
                        end else if (i_rx_data == CMD_STEP) begin
                            state <= ST_STEP;
                        end
                    end
                end
                ST_COUNT: begin
                    if (i_rx_done) begin
                        num_words <= i_rx_data;
                        word_cnt  <= '0;
                        byte_cnt  <= '0;
                        state     <= (i_rx_data == '0) ? ST_WAIT_CMD : ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (i_rx_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            word_cnt <= word_cnt + 1'b1;
                            if (word_cnt == num_words - 1'b1) begin
                                state <= ST_WAIT_CMD;
                            end
                        end
                    end
                end
                ST_RUN: begin
                    if (i_hlt) begin
                        state        <= ST_DUMP;
                        o_dump_start <= 1'b1;
                    end
                end
                ST_STEP: begin
                    // Single enabled cycle, then dump
                    state        <= ST_DUMP;
                    o_dump_start <= 1'b1;
                end
                ST_DUMP: begin
                    if (i_dump_done) begin
                        state <= ST_WAIT_CMD;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Words are only stored below the count received after CMD_LOAD
    a_im_write_in_range: assert property (
        @(posedge i_clock) disable iff (i_rst)
        o_im_we |-> (word_cnt < num_words)
    );

endmodule

//--- hw/instr_mem.sv
`timescale 1ns/100ps

module instr_mem #(
    parameter int NB_IM_ADDR = 4
) (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_we,
    input  logic [NB_IM_ADDR-1:0]       i_waddr,
    input  logic [dbg_pkg::NB_WORD-1:0] i_wdata,
    input  logic [NB_IM_ADDR-1:0]       i_raddr,
    output logic [dbg_pkg::NB_WORD-1:0] o_rdata
);
    import dbg_pkg::*;

    logic [NB_WORD-1:0]         mem [2**NB_IM_ADDR];
    logic [2**NB_IM_ADDR-1:0]   valid;

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            valid <= '0;
        end else if (i_we) begin
            valid[i_waddr] <= 1'b1;
        end
    end

    // Unwritten words read as zero, a no-op for the core
    assign o_rdata = valid[i_raddr] ? mem[i_raddr] : '0;

endmodule

//--- hw/reg_bank.sv
`timescale 1ns/100ps

module reg_bank #(
    parameter int NB_RB_ADDR = 3
) (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_clear,
    input  logic                        i_we,
    input  logic [NB_RB_ADDR-1:0]       i_waddr,
    input  logic [dbg_pkg::NB_WORD-1:0] i_wdata,
    input  logic [NB_RB_ADDR-1:0]       i_raddr_a,
    input  logic [NB_RB_ADDR-1:0]       i_raddr_b,
    input  logic [NB_RB_ADDR-1:0]       i_dbg_addr,
    output logic [dbg_pkg::NB_WORD-1:0] o_rdata_a,
    output logic [dbg_pkg::NB_WORD-1:0] o_rdata_b,
    output logic [dbg_pkg::NB_WORD-1:0] o_dbg_data
);
    import dbg_pkg::*;

    logic [NB_WORD-1:0] regs [2**NB_RB_ADDR];

    always_ff @(posedge i_clock) begin
        if (i_rst || i_clear) begin
            for (int i = 0; i < 2**NB_RB_ADDR; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = regs[i_raddr_a];
    assign o_rdata_b = regs[i_raddr_b];

    // Registered debug read
    always_ff @(posedge i_clock) begin
        o_dbg_data <= regs[i_dbg_addr];
    end

    // r0 stays zero at all times
    a_r0_zero: assert property (
        @(posedge i_clock) disable iff (i_rst)
        regs[0] == '0
    );

endmodule

//--- hw/exec_core.sv
`timescale 1ns/100ps

module exec_core #(
    parameter int NB_IM_ADDR = 4,
    parameter int NB_DM_ADDR = 3,
    parameter int NB_RB_ADDR = 3
) (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_enable,
    input  logic                        i_clear,
    input  logic [dbg_pkg::NB_WORD-1:0] i_instr,
    input  logic [dbg_pkg::NB_WORD-1:0] i_rs_data,
    input  logic [dbg_pkg::NB_WORD-1:0] i_rt_data,
    input  logic [NB_DM_ADDR-1:0]       i_dbg_dm_addr,
    output logic [dbg_pkg::NB_WORD-1:0] o_pc,
    output logic [NB_IM_ADDR-1:0]       o_im_addr,
    output logic [NB_RB_ADDR-1:0]       o_rs_addr,
    output logic [NB_RB_ADDR-1:0]       o_rt_addr,
    output logic                        o_rb_we,
    output logic [NB_RB_ADDR-1:0]       o_rb_waddr,
    output logic [dbg_pkg::NB_WORD-1:0] o_rb_wdata,
    output logic                        o_hlt,
    output logic [dbg_pkg::NB_WORD-1:0] o_dbg_dm_data
);
    import dbg_pkg::*;

    logic [NB_WORD-1:0]     pc;
    logic                   hlt;
    logic [NB_WORD-1:0]     dmem [2**NB_DM_ADDR];
    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [NB_WORD-1:0]     imm_ext;
    logic [NB_WORD-1:0]     addr_sum;
    logic [NB_DM_ADDR-1:0]  dm_addr;
    logic                   wr_en;
    logic                   dm_we;
    logic                   is_halt;
    logic                   run;

    assign opcode   = i_instr[31:26];
    assign funct    = i_instr[5:0];
    assign imm_ext  = {{(NB_WORD-16){i_instr[15]}}, i_instr[15:0]};
    assign addr_sum = i_rs_data + imm_ext;
    // Word address into data memory
    assign dm_addr  = addr_sum[NB_DM_ADDR+1:2];

    assign o_rs_addr = i_instr[21 +: NB_RB_ADDR];
    assign o_rt_addr = i_instr[16 +: NB_RB_ADDR];
    assign o_im_addr = pc[NB_IM_ADDR+1:2];
    assign o_pc      = pc;
    assign o_hlt     = hlt;

    // Nothing executes once halted
    assign run     = i_enable && !hlt;
    assign o_rb_we = run && wr_en;

    always_comb begin
        wr_en      = 1'b0;
        dm_we      = 1'b0;
        is_halt    = 1'b0;
        o_rb_waddr = i_instr[16 +: NB_RB_ADDR];
        o_rb_wdata = addr_sum;
        case (opcode)
            OP_RTYPE: begin
                o_rb_waddr = i_instr[11 +: NB_RB_ADDR];
                if (funct == FN_ADDU) begin
                    wr_en      = 1'b1;
                    o_rb_wdata = i_rs_data + i_rt_data;
                end else if (funct == FN_SUBU) begin
                    wr_en      = 1'b1;
                    o_rb_wdata = i_rs_data - i_rt_data;
                end
            end
            OP_ADDI: wr_en = 1'b1;
            OP_LW: begin
                wr_en      = 1'b1;
                o_rb_wdata = dmem[dm_addr];
            end
            OP_SW:   dm_we   = 1'b1;
            OP_HALT: is_halt = 1'b1;
            default: begin
            end
        endcase
    end

    // HALT keeps the PC on its own address
    always_ff @(posedge i_clock) begin
        if (i_rst || i_clear) begin
            pc  <= '0;
            hlt <= 1'b0;
        end else if (run) begin
            if (is_halt) begin
                hlt <= 1'b1;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst || i_clear) begin
            for (int i = 0; i < 2**NB_DM_ADDR; i++) begin
                dmem[i] <= '0;
            end
        end else if (run && dm_we) begin
            dmem[dm_addr] <= i_rt_data;
        end
    end

    always_ff @(posedge i_clock) begin
        o_dbg_dm_data <= dmem[i_dbg_dm_addr];
    end

endmodule

//--- hw/dump_sender.sv
`timescale 1ns/100ps

module dump_sender #(
    parameter int NB_DM_ADDR = 3,
    parameter int NB_RB_ADDR = 3
) (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_dump_start,
    input  logic                        i_tx_done,
    input  logic [dbg_pkg::NB_WORD-1:0] i_pc,
    input  logic [dbg_pkg::NB_WORD-1:0] i_rb_data,
    input  logic [dbg_pkg::NB_WORD-1:0] i_dm_data,
    output logic [NB_RB_ADDR-1:0]       o_rb_addr,
    output logic [NB_DM_ADDR-1:0]       o_dm_addr,
    output logic [dbg_pkg::NB_BYTE-1:0] o_tx_data,
    output logic                        o_tx_start,
    output logic                        o_dump_done
);
    import dbg_pkg::*;

    // Word 0 is the PC, then registers, then data memory
    localparam int N_REGS  = 2**NB_RB_ADDR;
    localparam int N_WORDS = 1 + N_REGS + 2**NB_DM_ADDR;
    localparam int NB_WIDX = $clog2(N_WORDS);
    localparam logic [NB_WIDX-1:0] DM_FIRST  = NB_WIDX'(1 + N_REGS);
    localparam logic [NB_WIDX-1:0] LAST_WORD = NB_WIDX'(N_WORDS - 1);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_SEND, S_WAIT} send_state_t;

    send_state_t        state;
    logic [NB_WIDX-1:0] widx;
    logic [1:0]         byte_idx;
    logic [NB_WORD-1:0] sel_word;
    logic [NB_WORD-1:0] word_q;
    logic [NB_WORD-1:0] cur_word;
    logic               tx_pending;

    assign o_rb_addr = NB_RB_ADDR'(widx - 1'b1);
    assign o_dm_addr = NB_DM_ADDR'(widx - DM_FIRST);

    always_comb begin
        if (widx == '0) begin
            sel_word = i_pc;
        end else if (widx < DM_FIRST) begin
            sel_word = i_rb_data;
        end else begin
            sel_word = i_dm_data;
        end
    end

    // First byte of a word comes straight from the debug read
    assign cur_word   = (state == S_SEND && byte_idx == 2'd0) ? sel_word : word_q;
    assign o_tx_data  = cur_word[NB_WORD - NB_BYTE - NB_BYTE*byte_idx +: NB_BYTE];
    assign o_tx_start = (state == S_SEND);
    assign o_dump_done = (state == S_WAIT) && i_tx_done && (byte_idx == 2'd3)
                         && (widx == LAST_WORD);

    always_ff @(posedge i_clock) begin
        if (state == S_SEND && byte_idx == 2'd0) begin
            word_q <= sel_word;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state    <= S_IDLE;
            widx     <= '0;
            byte_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_dump_start) begin
                        widx     <= '0;
                        byte_idx <= '0;
                        state    <= S_READ;
                    end
                end
                S_READ: state <= S_SEND;
                S_SEND: state <= S_WAIT;
                S_WAIT: begin
                    if (i_tx_done) begin
                        // wraps to 0 after the fourth byte
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx != 2'd3) begin
                            state <= S_READ;
                        end else if (widx == LAST_WORD) begin
                            state <= S_IDLE;
                        end else begin
                            widx  <= widx + 1'b1;
                            state <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            tx_pending <= 1'b0;
        end else if (o_tx_start) begin
            tx_pending <= 1'b1;
        end else if (i_tx_done) begin
            tx_pending <= 1'b0;
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge i_clock) disable iff (i_rst)
        o_tx_start |-> !tx_pending
    );

endmodule

//--- hw/top_of_tops.sv
`timescale 1ns/100ps

module top_of_tops #(
    parameter int NB_IM_ADDR = 4,
    parameter int NB_DM_ADDR = 3,
    parameter int NB_RB_ADDR = 3
) (
    input  logic                        i_clock,
    input  logic                        i_rst,
    input  logic                        i_rx_done,
    input  logic                        i_tx_done,
    input  logic [dbg_pkg::NB_BYTE-1:0] i_rx_data,
    output logic                        o_hlt,
    output dbg_pkg::debug_state_t       o_state,
    output logic [dbg_pkg::NB_BYTE-1:0] o_tx_data,
    output logic                        o_tx_start
);
    import dbg_pkg::*;

    logic                   im_we;
    logic [NB_IM_ADDR-1:0]  im_waddr;
    logic [NB_IM_ADDR-1:0]  im_raddr;
    logic [NB_WORD-1:0]     im_wdata;
    logic [NB_WORD-1:0]     instr;
    logic                   core_enable;
    logic                   core_clear;
    logic                   dump_start;
    logic                   dump_done;
    logic                   hlt;
    logic [NB_WORD-1:0]     pc;
    logic [NB_RB_ADDR-1:0]  rs_addr;
    logic [NB_RB_ADDR-1:0]  rt_addr;
    logic [NB_WORD-1:0]     rs_data;
    logic [NB_WORD-1:0]     rt_data;
    logic                   rb_we;
    logic [NB_RB_ADDR-1:0]  rb_waddr;
    logic [NB_WORD-1:0]     rb_wdata;
    logic [NB_RB_ADDR-1:0]  rb_dbg_addr;
    logic [NB_WORD-1:0]     rb_dbg_data;
    logic [NB_DM_ADDR-1:0]  dm_dbg_addr;
    logic [NB_WORD-1:0]     dm_dbg_data;

    assign o_hlt = hlt;

    debug_loader #(
        .NB_IM_ADDR (NB_IM_ADDR)
    ) u_debug_loader (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_rx_done     (i_rx_done),
        .i_rx_data     (i_rx_data),
        .i_hlt         (hlt),
        .i_dump_done   (dump_done),
        .o_im_we       (im_we),
        .o_im_addr     (im_waddr),
        .o_im_data     (im_wdata),
        .o_core_enable (core_enable),
        .o_core_clear  (core_clear),
        .o_dump_start  (dump_start),
        .o_state       (o_state)
    );

    instr_mem #(
        .NB_IM_ADDR (NB_IM_ADDR)
    ) u_instr_mem (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_we    (im_we),
        .i_waddr (im_waddr),
        .i_wdata (im_wdata),
        .i_raddr (im_raddr),
        .o_rdata (instr)
    );

    reg_bank #(
        .NB_RB_ADDR (NB_RB_ADDR)
    ) u_reg_bank (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_clear    (core_clear),
        .i_we       (rb_we),
        .i_waddr    (rb_waddr),
        .i_wdata    (rb_wdata),
        .i_raddr_a  (rs_addr),
        .i_raddr_b  (rt_addr),
        .i_dbg_addr (rb_dbg_addr),
        .o_rdata_a  (rs_data),
        .o_rdata_b  (rt_data),
        .o_dbg_data (rb_dbg_data)
    );

    exec_core #(
        .NB_IM_ADDR (NB_IM_ADDR),
        .NB_DM_ADDR (NB_DM_ADDR),
        .NB_RB_ADDR (NB_RB_ADDR)
    ) u_exec_core (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_enable      (core_enable),
        .i_clear       (core_clear),
        .i_instr       (instr),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_dbg_dm_addr (dm_dbg_addr),
        .o_pc          (pc),
        .o_im_addr     (im_raddr),
        .o_rs_addr     (rs_addr),
        .o_rt_addr     (rt_addr),
        .o_rb_we       (rb_we),
        .o_rb_waddr    (rb_waddr),
        .o_rb_wdata    (rb_wdata),
        .o_hlt         (hlt),
        .o_dbg_dm_data (dm_dbg_data)
    );

    dump_sender #(
        .NB_DM_ADDR (NB_DM_ADDR),
        .NB_RB_ADDR (NB_RB_ADDR)
    ) u_dump_sender (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_dump_start (dump_start),
        .i_tx_done    (i_tx_done),
        .i_pc         (pc),
        .i_rb_data    (rb_dbg_data),
        .i_dm_data    (dm_dbg_data),
        .o_rb_addr    (rb_dbg_addr),
        .o_dm_addr    (dm_dbg_addr),
        .o_tx_data    (o_tx_data),
        .o_tx_start   (o_tx_start),
        .o_dump_done  (dump_done)
    );

endmodule

//--- tb/tb_top_of_tops.sv
`timescale 1ns/100ps

module tb_top_of_tops;
    import dbg_pkg::*;

    localparam int NB_IM_ADDR = 4;
    localparam int NB_DM_ADDR = 3;
    localparam int NB_RB_ADDR = 3;
    // PC, registers and data words, four bytes each
    localparam int DUMP_BYTES = 4 * (1 + 2**NB_RB_ADDR + 2**NB_DM_ADDR);
    localparam int CYCLES_PER_LINE = 120;
    localparam string STIM_FILE = "tb/program_stim.txt";

    logic         clock;
    logic         rst;
    logic         rx_done;
    logic         tx_done;
    logic [7:0]   rx_data;
    logic         hlt;
    debug_state_t state;
    logic [7:0]   tx_data;
    logic         tx_start;

    logic [7:0]   got_q[$];
    logic [31:0]  fields[$];
    string        stim_lines[$];
    string        cur_test;
    int           errors;
    int           limit_cycles;
    int           dump_pos;

    top_of_tops #(
        .NB_IM_ADDR (NB_IM_ADDR),
        .NB_DM_ADDR (NB_DM_ADDR),
        .NB_RB_ADDR (NB_RB_ADDR)
    ) u_dut (
        .i_clock    (clock),
        .i_rst      (rst),
        .i_rx_done  (rx_done),
        .i_tx_done  (tx_done),
        .i_rx_data  (rx_data),
        .o_hlt      (hlt),
        .o_state    (state),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // ASCII digit or hex letter, -1 for anything else
    function automatic int hex_value(input byte c);
        int v;
        v = int'(c);
        if (v >= 48 && v <= 57) begin
            return v - 48;
        end else if (v >= 65 && v <= 70) begin
            return v - 55;
        end else if (v >= 97 && v <= 102) begin
            return v - 87;
        end
        return -1;
    endfunction

    // Hex tokens after the keyword character
    function automatic void split_fields(input string s);
        logic [31:0] acc;
        logic        in_tok;
        int          d;
        int          i;
        fields.delete();
        acc    = '0;
        in_tok = 1'b0;
        for (i = 1; i < s.len(); i++) begin
            d = hex_value(s.getc(i));
            if (d >= 0) begin
                acc    = {acc[27:0], 4'(d)};
                in_tok = 1'b1;
            end else if (in_tok) begin
                fields.push_back(acc);
                acc    = '0;
                in_tok = 1'b0;
            end
        end
        if (in_tok) begin
            fields.push_back(acc);
        end
    endfunction

    function automatic string strip_line(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0A || t.getc(t.len() - 1) == 8'h0D
                               || t.getc(t.len() - 1) == 8'h20)) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    task automatic read_stim();
        int    fd;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
                line = strip_line(line);
                if (line.len() > 0 && line.getc(0) != "#") begin
                    stim_lines.push_back(line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_rx_byte(input logic [7:0] b);
        @(posedge clock);
        #1;
        rx_data = b;
        rx_done = 1'b1;
        @(posedge clock);
        #1;
        rx_done = 1'b0;
        repeat (3) @(posedge clock);
    endtask

    task automatic wait_dump();
        dump_pos = 0;
        @(negedge clock);
        while (got_q.size() < DUMP_BYTES || state != ST_WAIT_CMD) begin
            @(negedge clock);
        end
        if (got_q.size() != DUMP_BYTES) begin
            $display("Test %s holds %0d tx bytes after the dump instead of %0d",
                     cur_test, got_q.size(), DUMP_BYTES);
            errors++;
        end
    endtask

    task automatic check_words();
        logic [31:0] word;
        logic [7:0]  exp_byte;
        logic [7:0]  act_byte;
        int          k;
        foreach (fields[w]) begin
            word = fields[w];
            for (k = 0; k < 4; k++) begin
                exp_byte = word[31 - 8*k -: 8];
                if (got_q.size() == 0) begin
                    $display("Test %s never received tx byte %0d", cur_test, dump_pos);
                    errors++;
                end else begin
                    act_byte = got_q.pop_front();
                    if (act_byte != exp_byte) begin
                        $display("Error: test %s byte %0d expected %02h actual %02h",
                                 cur_test, dump_pos, exp_byte, act_byte);
                        errors++;
                    end
                end
                dump_pos++;
            end
        end
    endtask

    task automatic run_stim();
        string line;
        foreach (stim_lines[n]) begin
            line = stim_lines[n];
            split_fields(line);
            case (line.getc(0))
                "T": cur_test = line.substr(2, line.len() - 1);
                "R": begin
                    foreach (fields[b]) begin
                        send_rx_byte(fields[b][7:0]);
                    end
                end
                "W": wait_dump();
                "E": check_words();
                default: begin
                    $display("Unknown stimulus line: %s", line);
                    errors++;
                end
            endcase
        end
    endtask

    // UART transmitter model with a random answer delay
    initial begin
        int gap;
        tx_done = 1'b0;
        void'($urandom(84));
        forever begin
            @(negedge clock);
            if (tx_start) begin
                got_q.push_back(tx_data);
                gap = $urandom_range(8, 1);
                repeat (gap) @(posedge clock);
                #1;
                tx_done = 1'b1;
                @(posedge clock);
                #1;
                tx_done = 1'b0;
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles in test %s, the dump never completed",
                 limit_cycles, cur_test);
        $display("Run stopped with %0d errors", errors + 1);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        rx_done      = 1'b0;
        rx_data      = 8'h00;
        errors       = 0;
        dump_pos     = 0;
        limit_cycles = 0;
        cur_test     = "none";
        read_stim();
        limit_cycles = stim_lines.size() * CYCLES_PER_LINE + 2000;
        repeat (16) @(posedge clock);
        #1;
        rst = 1'b0;
        run_stim();
        @(negedge clock);
        if (got_q.size() != 0) begin
            $display("Test %s left %0d tx bytes unchecked", cur_test, got_q.size());
            errors++;
        end
        if (hlt !== 1'b1) begin
            $display("Error: test %s hlt expected 1 actual %b", cur_test, hlt);
            errors++;
        end
        if (state != ST_WAIT_CMD) begin
            $display("Error: test %s state expected ST_WAIT_CMD actual %s",
                     cur_test, state.name());
            errors++;
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/program_stim.txt
# T test name | R rx bytes, one pulse each | W wait for a complete dump
# E expected dump words sent MSB first: PC and r0..r7, then data words 0..7
T load_run_alu
R 4C 05 20 01 00 05 20 02 00 0C 00 22 18 21 00 22 20 23 FC 00 00 00 43
W
E 00000010 00000000 00000005 0000000C 00000011 FFFFFFF9 00000000 00000000 00000000
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
T store_load_mem
R 4C 05 20 01 FF FE 20 02 00 10 AC 41 FF FC 8C 43 FF FC FC 00 00 00 43
W
E 00000010 00000000 FFFFFFFE 00000010 FFFFFFFE 00000000 00000000 00000000 00000000
E 00000000 00000000 00000000 FFFFFFFE 00000000 00000000 00000000 00000000
T r0_write
R 4C 03 20 00 00 07 20 05 00 03 FC 00 00 00 43
W
E 00000008 00000000 00000000 00000000 00000000 00000000 00000003 00000000 00000000
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
T step_mode
R 4C 04 20 01 00 01 20 22 00 02 00 22 18 21 FC 00 00 00
R 53
W
E 00000004 00000000 00000001 00000000 00000000 00000000 00000000 00000000 00000000
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
R 53
W
E 00000008 00000000 00000001 00000003 00000000 00000000 00000000 00000000 00000000
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
R 53
W
E 0000000C 00000000 00000001 00000003 00000004 00000000 00000000 00000000 00000000
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
T reload_clears
R 4C 03 20 07 FF FF AC 07 00 1C FC 00 00 00 43
W
E 00000008 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFFFFF
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFFFFF
R 4C 02 20 06 00 77 FC 00 00 00 43
W
E 00000004 00000000 00000000 00000000 00000000 00000000 00000000 00000077 00000000
E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

//--- sim.f
hw/dbg_pkg.sv
hw/debug_loader.sv
hw/instr_mem.sv
hw/reg_bank.sv
hw/exec_core.sv
hw/dump_sender.sv
hw/top_of_tops.sv
tb/tb_top_of_tops.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -f sim.f --top-module tb_top_of_tops -o sim_top
./obj_dir/sim_top | tee sim.log
if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    exit 1
fi
